// File: all.f
+incdir+hw
hw/fetch_pkg.sv
hw/fetch_stage.sv
hw/inst_sram.sv
hw/decode_stage.sv
hw/frontend_top.sv
tests/frontend_checker.sv
tests/frontend_tb.sv

// File: Makefile
TOP := frontend_tb

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@grep -q "^Simulation PASSED$$" sim.log

obj_dir/V$(TOP): all.f hw/*.sv hw/*.svh tests/*.sv
	verilator --binary --timing --timescale 1ns/1ps -f all.f \
		--top-module $(TOP) -o V$(TOP)

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f all.f \
		--top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

// File: tests/frontend_tests.txt
// per test: n_words stall_pct ex_step ex_entry n_records, then n_words program words
// ex_step 0 means no csr_reset; a test with n_words 0 ends the list
// sequential fetch, no stall
00000008 00000000 00000000 00000000 00000018
02800401 02800802 02800c03 0010150c 00151004 0380a005 28c00006 29800007
// b and bl, forward and backward; dead words are wrong path
0000000c 00000000 00000000 00000000 0000000e
02800401 50000c00 dead0002 dead0003 02800404 54001000
dead0006 02800407 50000c00 02800409 53fff7ff 0280040b
// sequential fetch under 40 percent stall
00000008 00000028 00000000 00000000 00000018
02800401 02800802 02800c03 0010150c 00151004 0380a005 28c00006 29800007
// csr_reset after 5 records, 25 percent stall
00000008 00000019 00000005 1c000100 00000014
02800401 02800802 02800c03 0010150c 00151004 0380a005 28c00006 29800007
// misaligned exception entry
00000004 0000000a 00000003 1c000202 0000000c
02800401 02800802 02800c03 0010150c
// branch as the 3rd record, then csr_reset at once
00000006 00000000 00000003 1c000040 0000000a
02800401 02800802 50002000 dead0003 dead0004 dead0005
// end of list
00000000

// File: tests/frontend_tb.sv
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module frontend_tb import fetch_pkg::*; ();

    logic        clk;
    logic        reset;
    logic        csr_reset;
    logic [31:0] ex_entry;
    logic        load_en;
    logic [31:0] load_addr;
    logic [31:0] load_data;
    logic        stall;
    logic        retire_valid;
    retire_t     retire;
    int          checked;
    int          errors;

    logic [31:0] test_words [0:255];

    frontend_top dut_i (
        .clk          (clk),
        .reset        (reset),
        .csr_reset    (csr_reset),
        .ex_entry     (ex_entry),
        .load_en      (load_en),
        .load_addr    (load_addr),
        .load_data    (load_data),
        .stall        (stall),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

    frontend_checker monitor_i (
        .clk          (clk),
        .reset        (reset),
        .csr_reset    (csr_reset),
        .ex_entry     (ex_entry),
        .load_en      (load_en),
        .load_addr    (load_addr),
        .load_data    (load_data),
        .stall        (stall),
        .retire_valid (retire_valid),
        .retire       (retire),
        .checked      (checked),
        .errors       (errors)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // opcode 000010 keeps fill words away from the branch decoder
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return {6'b000010, addr[27:2] ^ {22'd0, addr[31:28]} ^ {24'd0, addr[1:0]}};
    endfunction

    // program at the reset pc and the fill pattern elsewhere
    task automatic reset_and_load(input int base, input int nwords);
        logic [31:0] addr;
        @(negedge clk);
        reset = 1'b1;
        for (int i = 0; i < `IMEM_WORDS; i++) begin
            addr = `FETCH_RESET_PC + 32'(i) * 32'd4;
            @(negedge clk);
            load_en   = 1'b1;
            load_addr = addr;
            load_data = (i < nwords) ? test_words[base + i] : fill_word(addr);
        end
        @(negedge clk);
        load_en = 1'b0;
        repeat (5) @(negedge clk);
        reset = 1'b0;
    endtask

    initial begin
        int          ptr;
        int          test_num;
        int          nwords;
        int          ex_step;
        int          nrec;
        int          limit;
        int          cycles;
        int          total;
        int          prev_errors;
        logic [31:0] stall_pct;
        logic        fired;
        logic        timed_out;

        void'($urandom(32'h3c9c));
        reset     = 1'b1;
        csr_reset = 1'b0;
        ex_entry  = 32'd0;
        load_en   = 1'b0;
        load_addr = 32'd0;
        load_data = 32'd0;
        stall     = 1'b0;
        $readmemh("tests/frontend_tests.txt", test_words);

        ptr       = 0;
        test_num  = 0;
        total     = 0;
        timed_out = 1'b0;
        while (test_words[ptr] != 32'd0 && !timed_out) begin
            nwords      = int'(test_words[ptr]);
            stall_pct   = test_words[ptr + 1];
            ex_step     = int'(test_words[ptr + 2]);
            ex_entry    = test_words[ptr + 3];
            nrec        = int'(test_words[ptr + 4]);
            prev_errors = errors;
            test_num++;
            reset_and_load(ptr + 5, nwords);

            limit  = nrec * 20 + nrec * int'(stall_pct);
            cycles = 0;
            fired  = 1'b0;
            while (checked < nrec && cycles < limit) begin
                @(negedge clk);
                cycles++;
                stall     = (($urandom % 100) < stall_pct);
                csr_reset = 1'b0;
                // pulse right after the ex_step-th record has left
                if (ex_step != 0 && !fired && checked == ex_step) begin
                    csr_reset = 1'b1;
                    fired     = 1'b1;
                end
            end
            @(negedge clk);
            csr_reset = 1'b0;
            stall     = 1'b0;

            total += checked;
            if (checked < nrec) begin
                $display("timeout in test %0d: only %0d of %0d records retired in %0d cycles",
                         test_num, checked, nrec, cycles);
                timed_out = 1'b1;
            end else begin
                $display("test %0d: %0d records checked, %0d mismatches",
                         test_num, checked, errors - prev_errors);
            end
            ptr += 5 + nwords;
        end

        if (test_num == 0) begin
            $display("no tests were read from tests/frontend_tests.txt");
        end
        $display("tests run %0d, records checked %0d, mismatches %0d", test_num, total, errors);
        if (errors == 0 && !timed_out && test_num > 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: tests/frontend_checker.sv
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module frontend_checker import fetch_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        csr_reset,
    input  logic [31:0] ex_entry,
    input  logic        load_en,
    input  logic [31:0] load_addr,
    input  logic [31:0] load_data,
    input  logic        stall,
    input  logic        retire_valid,
    input  retire_t     retire,
    output int          checked,
    output int          errors
);

    // memory copy built from the load port
    logic [31:0] mem_model [`IMEM_WORDS];
    logic [31:0] ref_pc;
    int          record_count = 0;
    int          mismatch_count = 0;

    assign checked = record_count;
    assign errors  = mismatch_count;

    function automatic int word_index(input logic [31:0] addr);
        return int'((addr >> 2) % `IMEM_WORDS);
    endfunction

    function automatic logic is_branch_word(input logic [31:0] inst);
        return (inst[31:26] == 6'b010100) || (inst[31:26] == 6'b010101);
    endfunction

    // word offset made of inst[9:0] then inst[25:10]
    function automatic logic [31:0] branch_dest(input logic [31:0] pc,
                                                input logic [31:0] inst);
        logic [25:0] offs;
        logic [31:0] byte_offs;
        offs      = {inst[9:0], inst[25:10]};
        byte_offs = {{6{offs[25]}}, offs} << 2;
        return pc + byte_offs;
    endfunction

    task automatic compare(input string name, input logic [31:0] exp,
                           input logic [31:0] act);
        if (act !== exp) begin
            $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
            mismatch_count++;
        end
    endtask

    always @(posedge clk) begin
        logic        exp_adef;
        logic [31:0] exp_inst;
        logic        exp_br;
        if (reset) begin
            if (load_en) begin
                mem_model[word_index(load_addr)] = load_data;
            end
            ref_pc       = `FETCH_RESET_PC;
            record_count = 0;
        end else if (csr_reset) begin
            // buffer flushed so nothing leaves this cycle
            compare("retire_valid", 32'd0, {31'd0, retire_valid});
            // next record comes from the exception entry
            ref_pc = ex_entry;
        end else if (retire_valid && !stall) begin
            exp_adef = (ref_pc[1:0] != 2'b00);
            exp_inst = exp_adef ? 32'd0 : mem_model[word_index(ref_pc)];
            exp_br   = !exp_adef && is_branch_word(exp_inst);
            compare("retire.pc", ref_pc, retire.pc);
            compare("retire.inst", exp_inst, retire.inst);
            compare("retire.adef", {31'd0, exp_adef}, {31'd0, retire.adef});
            compare("retire.is_branch", {31'd0, exp_br}, {31'd0, retire.is_branch});
            record_count++;
            ref_pc = exp_br ? branch_dest(ref_pc, exp_inst) : ref_pc + 32'd4;
        end
    end

endmodule

// File: hw/frontend_top.sv
`timescale 1ns/1ps

module frontend_top import fetch_pkg::*; (
    input  logic        clk,
    input  logic        reset,

    // exception redirect
    input  logic        csr_reset,
    input  logic [31:0] ex_entry,

    // program preload, only while reset is high
    input  logic        load_en,
    input  logic [31:0] load_addr,
    input  logic [31:0] load_data,

    // retire port
    input  logic        stall,
    output logic        retire_valid,
    output retire_t     retire
);

    // the instruction bus is read only, so wr/size/wstrb/wdata are not carried
    logic        sram_req;
    logic [31:0] sram_addr;
    logic        sram_addr_ok;
    logic        sram_data_ok;
    logic [31:0] sram_rdata;

    logic        id_allow_in;
    logic        to_id_valid;
    if_id_t      to_id;
    br_info_t    br;

    fetch_stage u_fetch (
        .clk          (clk),
        .reset        (reset),
        .csr_reset    (csr_reset),
        .ex_entry     (ex_entry),
        .br           (br),
        .sram_req     (sram_req),
        .sram_addr    (sram_addr),
        .sram_addr_ok (sram_addr_ok),
        .sram_data_ok (sram_data_ok),
        .sram_rdata   (sram_rdata),
        .id_allow_in  (id_allow_in),
        .to_id_valid  (to_id_valid),
        .to_id        (to_id)
    );

    inst_sram u_sram (
        .clk       (clk),
        .reset     (reset),
        .req       (sram_req),
        .addr      (sram_addr),
        .addr_ok   (sram_addr_ok),
        .data_ok   (sram_data_ok),
        .rdata     (sram_rdata),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data)
    );

    decode_stage u_decode (
        .clk           (clk),
        .reset         (reset),
        .csr_reset     (csr_reset),
        .from_if_valid (to_id_valid),
        .from_if       (to_id),
        .allow_in      (id_allow_in),
        .br            (br),
        .stall         (stall),
        .retire_valid  (retire_valid),
        .retire        (retire)
    );

endmodule

// File: hw/decode_stage.sv
`timescale 1ns/1ps

module decode_stage import fetch_pkg::*; (
    input  logic     clk,
    input  logic     reset,

    input  logic     csr_reset,

    // from fetch
    input  logic     from_if_valid,
    input  if_id_t   from_if,
    output logic     allow_in,

    // redirect back to fetch, same cycle as acceptance
    output br_info_t br,

    // retire port
    input  logic     stall,
    output logic     retire_valid,
    output retire_t  retire
);

    retire_t     buf_r;
    logic        buf_valid;
    logic        accept;
    logic        leave;
    branch_op_e  op;
    logic        is_branch;
    logic [25:0] offs;
    logic [31:0] target;

    function automatic branch_op_e classify(input logic [31:0] inst);
        branch_op_e kind;
        case (inst[31:26])
            6'b010100: kind = op_b;
            6'b010101: kind = op_bl;
            default:   kind = op_none;
        endcase
        return kind;
    endfunction

    assign op        = classify(from_if.inst);
    assign is_branch = (op == op_b || op == op_bl) && !from_if.adef;

    // offs26 is stored low half first, inst[9:0] holds the upper bits
    assign offs   = {from_if.inst[9:0], from_if.inst[25:10]};
    assign target = from_if.pc + {{4{offs[25]}}, offs, 2'b00};

    // a flushed record never leaves
    assign retire_valid = buf_valid && !csr_reset;
    assign leave        = retire_valid && !stall;
    assign allow_in     = !buf_valid || leave;
    assign accept       = from_if_valid && allow_in && !csr_reset;

    assign br.taken  = accept && is_branch;
    assign br.target = target;

    always_ff @(posedge clk) begin
        if (reset || csr_reset) begin
            buf_valid <= 1'b0;
        end else if (accept) begin
            buf_valid <= 1'b1;
        end else if (leave) begin
            buf_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            buf_r.pc        <= from_if.pc;
            buf_r.inst      <= from_if.inst;
            buf_r.adef      <= from_if.adef;
            buf_r.is_branch <= is_branch;
        end
    end

    assign retire = buf_r;

endmodule

// File: hw/inst_sram.sv
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module inst_sram (
    input  logic        clk,
    input  logic        reset,

    input  logic        req,
    input  logic [31:0] addr,
    output logic        addr_ok,
    output logic        data_ok,
    output logic [31:0] rdata,

    // preload port, byte address like the fetch bus
    input  logic        load_en,
    input  logic [31:0] load_addr,
    input  logic [31:0] load_data
);

    localparam int AW = $clog2(`IMEM_WORDS);
    localparam int CW = $clog2(`SRAM_MAX_DELAY + 1);

    typedef enum logic {
        sram_idle,
        sram_busy
    } sram_state_e;

    sram_state_e state;

    logic [31:0]   mem [`IMEM_WORDS];
    logic [15:0]   lfsr;
    logic [CW-1:0] wait_cnt;
    logic [CW-1:0] grant_dly;
    logic [CW-1:0] return_dly;
    logic          accept;

    // galois lfsr, x^16 + x^14 + x^13 + x^11 + 1
    always_ff @(posedge clk) begin
        if (reset) begin
            lfsr <= 16'hace1;
        end else begin
            lfsr <= {1'b0, lfsr[15:1]} ^ (lfsr[0] ? 16'hb400 : 16'h0000);
        end
    end

    // grant waits 0..max, data returns 1..max cycles after grant
    assign grant_dly  = CW'(lfsr[7:0] % 8'(`SRAM_MAX_DELAY + 1));
    assign return_dly = CW'(lfsr[15:8] % 8'(`SRAM_MAX_DELAY));

    assign addr_ok = (state == sram_idle) && (wait_cnt == '0);
    assign data_ok = (state == sram_busy) && (wait_cnt == '0);
    assign accept  = req && addr_ok;

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= sram_idle;
            wait_cnt <= '0;
        end else if (state == sram_idle) begin
            if (accept) begin
                state    <= sram_busy;
                wait_cnt <= return_dly;
            end else if (wait_cnt != '0) begin
                wait_cnt <= wait_cnt - 1'b1;
            end
        end else begin
            if (data_ok) begin
                state    <= sram_idle;
                wait_cnt <= grant_dly;
            end else begin
                wait_cnt <= wait_cnt - 1'b1;
            end
        end
    end

    // word read at grant, held until data_ok
    always_ff @(posedge clk) begin
        if (reset && load_en) begin
            mem[load_addr[AW+1:2]] <= load_data;
        end
        if (!reset && accept) begin
            rdata <= mem[addr[AW+1:2]];
        end
    end

endmodule

// File: hw/fetch_stage.sv
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module fetch_stage import fetch_pkg::*; (
    input  logic        clk,
    input  logic        reset,

    // exception redirect
    input  logic        csr_reset,
    input  logic [31:0] ex_entry,

    // branch redirect from decode
    input  br_info_t    br,

    // instruction SRAM, request and data phases
    output logic        sram_req,
    output logic [31:0] sram_addr,
    input  logic        sram_addr_ok,
    input  logic        sram_data_ok,
    input  logic [31:0] sram_rdata,

    // hand-off to decode
    input  logic        id_allow_in,
    output logic        to_id_valid,
    output if_id_t      to_id
);

    fetch_state_e state;

    logic [31:0] pc;
    logic [31:0] inst_r;
    logic [31:0] seq_pc;
    logic [31:0] next_pc;
    logic        need_jump;
    logic        ready_go;
    logic        adef;

    // exception entry beats branch target beats sequential
    assign seq_pc    = pc + 32'd4;
    assign need_jump = csr_reset | br.taken;
    assign next_pc   = csr_reset ? ex_entry :
                       br.taken  ? br.target :
                                   seq_pc;

    assign adef = (pc[1:0] != 2'b00);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= fs_req;
            pc    <= `FETCH_RESET_PC;
        end else begin
            case (state)
                fs_req: begin
                    // not granted yet, just retarget the pending request
                    if (need_jump) begin
                        pc <= next_pc;
                    end
                    if (sram_addr_ok) begin
                        // granted for the old pc, its data is stale
                        if (need_jump) begin
                            state <= fs_need_cancel;
                        end else begin
                            state <= fs_wait_for_ok;
                        end
                    end
                end

                fs_wait_for_ok: begin
                    if (sram_data_ok) begin
                        if (need_jump || id_allow_in) begin
                            state <= fs_req;
                            pc    <= next_pc;
                        end else begin
                            state <= fs_wait_for_id;
                        end
                    end else if (need_jump) begin
                        state <= fs_need_cancel;
                        pc    <= next_pc;
                    end
                end

                fs_wait_for_id: begin
                    // a redirect drops the held word
                    if (need_jump || id_allow_in) begin
                        state <= fs_req;
                        pc    <= next_pc;
                    end
                end

                fs_need_cancel: begin
                    // a later exception still overrides the saved target
                    if (need_jump) begin
                        pc <= next_pc;
                    end
                    if (sram_data_ok) begin
                        state <= fs_req;
                    end
                end

                default: begin
                    state <= fs_req;
                end
            endcase
        end
    end

    // hold the returned word while decode is full
    always_ff @(posedge clk) begin
        if (state == fs_wait_for_ok && sram_data_ok) begin
            inst_r <= sram_rdata;
        end
    end

    assign sram_req  = (state == fs_req);
    assign sram_addr = pc;

    assign ready_go = (state == fs_wait_for_ok && sram_data_ok) ||
                      (state == fs_wait_for_id);

    assign to_id_valid = ready_go;

    always_comb begin
        to_id.pc   = pc;
        to_id.adef = adef;
        if (adef) begin
            to_id.inst = 32'd0;
        end else if (state == fs_wait_for_ok) begin
            to_id.inst = sram_rdata;
        end else begin
            to_id.inst = inst_r;
        end
    end

endmodule

// File: hw/fetch_pkg.sv
package fetch_pkg;

    // fetch request FSM
    typedef enum logic [1:0] {
        fs_req         = 2'd0,
        fs_wait_for_ok = 2'd1,
        fs_wait_for_id = 2'd2,
        fs_need_cancel = 2'd3
    } fetch_state_e;

    // instruction kinds seen by decode
    typedef enum logic [1:0] {
        op_none = 2'd0,
        op_b    = 2'd1,
        op_bl   = 2'd2
    } branch_op_e;

    // redirect from decode back to fetch
    typedef struct packed {
        logic        taken;
        logic [31:0] target;
    } br_info_t;

    // fetch to decode record
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        logic        adef;
    } if_id_t;

    // record leaving the front end
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        logic        adef;
        logic        is_branch;
    } retire_t;

endpackage

// File: hw/fetch_cfg.svh
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// first fetch address after reset
`define FETCH_RESET_PC 32'h1c000000

// instruction memory depth in 32-bit words
// addresses wrap modulo this depth
`define IMEM_WORDS 1024

// longest wait before addr_ok, and again before data_ok
`define SRAM_MAX_DELAY 3

`endif
